// ==== files.f ====
design/ecc_mem_pkg.sv
design/secded_encode.sv
design/secded_decode.sv
design/ecc_word_store.sv
design/ecc_ctrl_regs.sv
design/ecc_mem_top.sv
testbench/ecc_mem_chk.sv
testbench/ecc_mem_tb.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert --timescale 1ns/100ps
TOP       = ecc_mem_tb
FILELIST  = files.f
OBJ_DIR   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== testbench/ecc_mem_tb.sv ====
// ECC memory testbench
`timescale 1ns/100ps
`default_nettype none

module ecc_mem_tb
   import ecc_mem_pkg::*;
();

   logic        clk;
   logic        rst_l;
   logic        cyc;
   logic        stb;
   logic        we;
   wb_adr_t     adr;
   data_t       dat_w;
   data_t       dat_r;
   logic        ack;
   logic        err;

   logic [31:0] lcg_state;
   int          last_cycles;   // edges from request to response
   int          exp_single;
   int          exp_double;

   ecc_mem_top i_ecc_mem_top (
      .clk   (clk),
      .rst_l (rst_l),
      .cyc   (cyc),
      .stb   (stb),
      .we    (we),
      .adr   (adr),
      .dat_w (dat_w),
      .dat_r (dat_r),
      .ack   (ack),
      .err   (err)
   );

   always #50 clk = ~clk;

   // about 90 transfers of at most 6 cycles each, so 2000 cycles is ample
   initial
   begin
      repeat (2000) @(posedge clk);
      $display("watchdog expired, the tests did not finish within 2000 clock cycles");
      $display("Test FAILED");
      $fatal(1);
   end

   function automatic data_t next_random();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   // codeword from the position rule, built bit by bit
   function automatic codeword_t encode_reference(data_t d);
      codeword_t c;
      int        n;
      logic      p;
      c = '0;
      n = 0;
      for (int pos = 3; pos < CODE_W; pos++)
      begin
         if ((pos & (pos - 1)) != 0)   // not a power of two
         begin
            c[pos] = d[n];
            n++;
         end
      end
      for (int k = 0; k < CHECK_W; k++)
      begin
         p = 1'b0;
         for (int pos = 3; pos < CODE_W; pos++)
         begin
            if (((pos >> k) & 1) == 1)
               p ^= c[pos];
         end
         c[1 << k] = p;
      end
      c[0] = ^c[CODE_W-1:1];
      return c;
   endfunction

   // expected {double, single} of a read, and the data it returns
   function automatic logic [1:0] decode_reference(codeword_t c, logic detect, output data_t d);
      logic [5:0] s;
      logic       p;
      logic [1:0] outcome;
      codeword_t  f;
      int         n;
      s = '0;
      for (int pos = 1; pos < CODE_W; pos++)
      begin
         if (c[pos])
            s ^= 6'(pos);
      end
      p = ^c;
      f = c;
      if (detect)
         outcome = {p | (s != 6'd0), 1'b0};
      else if (!p && s == 6'd0)
         outcome = 2'b00;
      else if (p && s == 6'd0)
         outcome = 2'b01;   // only the parity bit flipped
      else if (p && s < 6'(CODE_W))
      begin
         outcome = 2'b01;
         f[s] = ~f[s];
      end
      else
         outcome = 2'b10;
      d = '0;
      n = 0;
      for (int pos = 3; pos < CODE_W; pos++)
      begin
         if ((pos & (pos - 1)) != 0)
         begin
            d[n] = f[pos];
            n++;
         end
      end
      return outcome;
   endfunction

   task automatic expect_equal(string test, string what, data_t expected, data_t actual);
      assert (actual === expected)
      else
      begin
         $display("Fail %s %s: expected %0h, actual %0h", test, what, expected, actual);
         $display("Test FAILED");
         $fatal(1);
      end
   endtask

   // request held through the response cycle, then one idle cycle
   task automatic bus_transfer(input logic write, input wb_adr_t a, input data_t wdata,
                               output data_t rdata, output logic got_err);
      last_cycles = 0;
      cyc         = 1'b1;
      stb         = 1'b1;
      we          = write;
      adr         = a;
      dat_w       = wdata;
      while (!(ack || err))
      begin
         @(posedge clk);
         #10;
         last_cycles++;
         if (last_cycles >= 16 && !(ack || err))
         begin
            $display("no ack or err from the DUT within 16 cycles at address %0d", a);
            $display("Test FAILED");
            $fatal(1);
         end
      end
      rdata   = dat_r;
      got_err = err;
      @(posedge clk);
      #10;
      cyc = 1'b0;
      stb = 1'b0;
      we  = 1'b0;
      @(posedge clk);
      #10;
   endtask

   task automatic wb_write(input wb_adr_t a, input data_t d);
      data_t unused;
      logic  got_err;
      bus_transfer(1'b1, a, d, unused, got_err);
      expect_equal("bus_write", "err", '0, 32'(got_err));
   endtask

   task automatic wb_read(input wb_adr_t a, output data_t rdata, output logic got_err);
      bus_transfer(1'b0, a, '0, rdata, got_err);
   endtask

   task automatic compare_counters(string test);
      data_t st;
      logic  got_err;
      wb_read(REG_STATUS_ADR, st, got_err);
      expect_equal(test, "status err", '0, 32'(got_err));
      expect_equal(test, "single_count", data_t'(exp_single), 32'(st[7:0]));
      expect_equal(test, "double_count", data_t'(exp_double), 32'(st[15:8]));
   endtask

   task automatic clean_round_trip();
      data_t written [MEM_DEPTH];
      data_t rdata;
      logic  got_err;
      for (int i = 0; i < MEM_DEPTH; i++)
      begin
         written[i] = next_random();
         wb_write(wb_adr_t'(i), written[i]);
      end
      for (int i = 0; i < MEM_DEPTH; i++)
      begin
         wb_read(wb_adr_t'(i), rdata, got_err);
         expect_equal("clean_round_trip", "err", '0, 32'(got_err));
         expect_equal("clean_round_trip", "data", written[i], rdata);
      end
      compare_counters("clean_round_trip");
   endtask

   task automatic single_error_correction();
      bit_idx_t   idx [4];
      string      name;
      wb_adr_t    a;
      data_t      d;
      data_t      inj;
      data_t      rdata;
      data_t      exp_data;
      logic       got_err;
      logic [1:0] outcome;
      name = "single_error_correction";
      idx  = '{6'd0, 6'd3, 6'd20, 6'd38};
      for (int i = 0; i < 4; i++)
      begin
         a        = wb_adr_t'(i + 2);
         d        = next_random();
         inj      = '0;
         inj[5:0] = idx[i];
         inj[6]   = 1'b1;   // enable a only
         wb_write(REG_INJECT_ADR, inj);
         wb_read(REG_INJECT_ADR, rdata, got_err);
         expect_equal(name, "inject readback", inj, rdata);
         wb_write(a, d);
         wb_read(REG_INJECT_ADR, rdata, got_err);
         expect_equal(name, "inject after write", '0, rdata);
         outcome = decode_reference(encode_reference(d) ^ (codeword_t'(1) << idx[i]), 1'b0,
                                    exp_data);
         exp_single += int'(outcome[0]);
         exp_double += int'(outcome[1]);
         wb_read(a, rdata, got_err);
         expect_equal(name, "err", 32'(outcome[1]), 32'(got_err));
         expect_equal(name, "data", exp_data, rdata);
         compare_counters(name);
         // rewrite must store a clean word
         d = next_random();
         wb_write(a, d);
         wb_read(a, rdata, got_err);
         expect_equal(name, "clean rewrite err", '0, 32'(got_err));
         expect_equal(name, "clean rewrite data", d, rdata);
         compare_counters(name);
      end
   endtask

   task automatic double_error_detection();
      bit_idx_t   idx_a [3];
      bit_idx_t   idx_b [3];
      string      name;
      wb_adr_t    a;
      data_t      d;
      data_t      inj;
      data_t      rdata;
      data_t      exp_data;
      logic       got_err;
      logic [1:0] outcome;
      codeword_t  mask;
      name  = "double_error_detection";
      idx_a = '{6'd5, 6'd0, 6'd33};
      idx_b = '{6'd30, 6'd12, 6'd6};
      for (int i = 0; i < 3; i++)
      begin
         a          = wb_adr_t'(i + 10);
         d          = next_random();
         inj        = '0;
         inj[5:0]   = idx_a[i];
         inj[6]     = 1'b1;
         inj[13:8]  = idx_b[i];
         inj[14]    = 1'b1;
         mask       = (codeword_t'(1) << idx_a[i]) | (codeword_t'(1) << idx_b[i]);
         wb_write(REG_INJECT_ADR, inj);
         wb_write(a, d);
         outcome = decode_reference(encode_reference(d) ^ mask, 1'b0, exp_data);
         exp_single += int'(outcome[0]);
         exp_double += int'(outcome[1]);
         wb_read(a, rdata, got_err);
         expect_equal(name, "err", 32'(outcome[1]), 32'(got_err));
         expect_equal(name, "data", exp_data, rdata);
         compare_counters(name);
      end
   endtask

   task automatic detect_only_mode();
      string      name;
      data_t      d;
      data_t      inj;
      data_t      rdata;
      data_t      exp_data;
      logic       got_err;
      logic [1:0] outcome;
      name = "detect_only_mode";
      wb_write(REG_CTRL_ADR, 32'd1);
      wb_read(REG_CTRL_ADR, rdata, got_err);
      expect_equal(name, "ctrl readback", 32'd1, rdata);
      d        = next_random();
      inj      = '0;
      inj[5:0] = 6'd20;
      inj[6]   = 1'b1;
      wb_write(REG_INJECT_ADR, inj);
      wb_write(5'd14, d);
      outcome = decode_reference(encode_reference(d) ^ (codeword_t'(1) << 20), 1'b1, exp_data);
      exp_single += int'(outcome[0]);
      exp_double += int'(outcome[1]);
      wb_read(5'd14, rdata, got_err);
      expect_equal(name, "err", 32'(outcome[1]), 32'(got_err));
      expect_equal(name, "data", exp_data, rdata);   // raw, not corrected
      compare_counters(name);
      wb_write(REG_CTRL_ADR, '0);
   endtask

   task automatic status_and_timing();
      string name;
      data_t d;
      data_t rdata;
      logic  got_err;
      name = "status_and_timing";
      wb_write(REG_STATUS_ADR, next_random());
      expect_equal(name, "register write cycles", 32'd1, data_t'(last_cycles));
      exp_single = 0;
      exp_double = 0;
      compare_counters(name);
      expect_equal(name, "register read cycles", 32'd1, data_t'(last_cycles));
      d = next_random();
      wb_write(5'd7, d);
      expect_equal(name, "memory write cycles", 32'd1, data_t'(last_cycles));
      wb_read(5'd7, rdata, got_err);
      expect_equal(name, "memory read cycles", 32'd2, data_t'(last_cycles));
      expect_equal(name, "memory read err", '0, 32'(got_err));
      expect_equal(name, "memory read data", d, rdata);
      wb_read(5'd31, rdata, got_err);
      expect_equal(name, "unmapped read cycles", 32'd1, data_t'(last_cycles));
      expect_equal(name, "unmapped read err", '0, 32'(got_err));
      expect_equal(name, "unmapped read data", '0, rdata);
      // an unmapped write must not reach any register
      wb_write(5'd31, next_random());
      wb_read(REG_CTRL_ADR, rdata, got_err);
      expect_equal(name, "ctrl after unmapped write", '0, rdata);
      wb_read(REG_INJECT_ADR, rdata, got_err);
      expect_equal(name, "inject after unmapped write", '0, rdata);
   endtask

   initial
   begin
      clk        = 1'b0;
      rst_l      = 1'b0;
      cyc        = 1'b0;
      stb        = 1'b0;
      we         = 1'b0;
      adr        = '0;
      dat_w      = '0;
      lcg_state  = 32'd82784;
      exp_single = 0;
      exp_double = 0;
      repeat (5) @(posedge clk);
      #10;
      rst_l = 1'b1;
      clean_round_trip();
      single_error_correction();
      double_error_detection();
      detect_only_mode();
      status_and_timing();
      $display("Test OK");
      $finish;
   end

endmodule

`default_nettype wire

// ==== testbench/ecc_mem_chk.sv ====
// Wishbone handshake checks
`timescale 1ns/100ps
`default_nettype none

module ecc_mem_chk
(
   input logic clk,
   input logic rst_l,
   input logic cyc,
   input logic stb,
   input logic ack,
   input logic err
);

   // a transfer ends with one response, never both
   ack_err_exclusive: assert property (@(posedge clk) disable iff (!rst_l) !(ack && err))
      else $error("ack and err are high in the same cycle");

   resp_needs_req: assert property (@(posedge clk) disable iff (!rst_l)
      (ack || err) |-> (cyc && stb))
      else $error("response without cyc and stb");

   ack_single_cycle: assert property (@(posedge clk) disable iff (!rst_l) ack |=> !ack)
      else $error("ack held for more than one cycle");

   err_single_cycle: assert property (@(posedge clk) disable iff (!rst_l) err |=> !err)
      else $error("err held for more than one cycle");

endmodule

bind ecc_mem_top ecc_mem_chk i_ecc_mem_chk (
   .clk   (clk),
   .rst_l (rst_l),
   .cyc   (cyc),
   .stb   (stb),
   .ack   (ack),
   .err   (err)
);

`default_nettype wire

// ==== design/ecc_mem_top.sv ====
// ECC protected memory with Wishbone slave
`timescale 1ns/100ps
`default_nettype none

module ecc_mem_top
   import ecc_mem_pkg::*;
(
   input  logic    clk,
   input  logic    rst_l,
   input  logic    cyc,
   input  logic    stb,
   input  logic    we,
   input  wb_adr_t adr,
   input  data_t   dat_w,
   output data_t   dat_r,
   output logic    ack,
   output logic    err
);

   bus_state_t state;
   bus_state_t next_state;
   logic       req;       // new transfer sampled in idle
   logic       mem_sel;
   logic       wr_en;
   logic       rd_en;
   logic       reg_wr;
   logic       reg_rd;
   logic       rd_done;   // decoded word is on rd_code
   word_addr_t mem_addr;
   codeword_t  enc_code;
   codeword_t  wr_code;
   codeword_t  rd_code;
   codeword_t  inject_mask;
   data_t      dec_data;
   data_t      reg_rdata;
   logic       detect_only;
   logic       single_err;
   logic       double_err;
   logic       count_single;
   logic       count_double;

   assign req      = (state == bus_idle) & cyc & stb;
   assign mem_sel  = ~adr[4];   // upper half is register space
   assign wr_en    = req & we & mem_sel;
   assign rd_en    = req & ~we & mem_sel;
   assign reg_wr   = req & we & ~mem_sel;
   assign reg_rd   = req & ~we & ~mem_sel;
   assign rd_done  = (state == bus_read);
   assign mem_addr = adr[3:0];

   assign wr_code      = enc_code ^ inject_mask;   // fault injection after encoding
   assign count_single = rd_done & single_err;
   assign count_double = rd_done & double_err;

   always_comb
   begin
      next_state = state;
      case (state)
         bus_idle:
         begin
            if (rd_en)
               next_state = bus_read;
            else if (req)
               next_state = bus_done;
         end
         bus_read:
            next_state = bus_done;
         default:
            next_state = bus_idle;   // gap cycle after every transfer
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (!rst_l)
      begin
         state <= bus_idle;
         ack   <= 1'b0;
         err   <= 1'b0;
      end
      else
      begin
         state <= next_state;
         ack   <= (req & ~rd_en) | (rd_done & ~double_err);
         err   <= rd_done & double_err;
      end
   end

   always_ff @(posedge clk)
   begin
      if (reg_rd)
         dat_r <= reg_rdata;
      else if (rd_done)
         dat_r <= dec_data;   // returned even on err
   end

   secded_encode i_secded_encode (
      .data (dat_w),
      .code (enc_code)
   );

   ecc_word_store i_ecc_word_store (
      .clk     (clk),
      .wr_en   (wr_en),
      .wr_addr (mem_addr),
      .wr_code (wr_code),
      .rd_en   (rd_en),
      .rd_addr (mem_addr),
      .rd_code (rd_code)
   );

   secded_decode i_secded_decode (
      .code        (rd_code),
      .detect_only (detect_only),
      .data        (dec_data),
      .single_err  (single_err),
      .double_err  (double_err)
   );

   ecc_ctrl_regs i_ecc_ctrl_regs (
      .clk          (clk),
      .rst_l        (rst_l),
      .reg_wr       (reg_wr),
      .reg_sel      (adr),
      .reg_wdata    (dat_w),
      .mem_write    (wr_en),
      .count_single (count_single),
      .count_double (count_double),
      .detect_only  (detect_only),
      .inject_mask  (inject_mask),
      .reg_rdata    (reg_rdata)
   );

endmodule

`default_nettype wire

// ==== design/ecc_ctrl_regs.sv ====
// ECC control and status registers
`timescale 1ns/100ps
`default_nettype none

module ecc_ctrl_regs
   import ecc_mem_pkg::*;
(
   input  logic      clk,
   input  logic      rst_l,
   input  logic      reg_wr,
   input  wb_adr_t   reg_sel,
   input  data_t     reg_wdata,
   input  logic      mem_write,
   input  logic      count_single,
   input  logic      count_double,
   output logic      detect_only,
   output codeword_t inject_mask,
   output data_t     reg_rdata
);

   bit_idx_t   inj_idx_a;
   logic       inj_en_a;
   bit_idx_t   inj_idx_b;
   logic       inj_en_b;
   err_count_t single_count;
   err_count_t double_count;

   always_ff @(posedge clk)
   begin
      if (!rst_l)
      begin
         detect_only <= 1'b0;
         inj_idx_a   <= '0;
         inj_en_a    <= 1'b0;
         inj_idx_b   <= '0;
         inj_en_b    <= 1'b0;
      end
      else
      begin
         if (reg_wr && reg_sel == REG_CTRL_ADR)
            detect_only <= reg_wdata[0];
         if (reg_wr && reg_sel == REG_INJECT_ADR)
         begin
            inj_idx_a <= reg_wdata[5:0];
            inj_en_a  <= reg_wdata[6];
            inj_idx_b <= reg_wdata[13:8];
            inj_en_b  <= reg_wdata[14];
         end
         else if (mem_write)
         begin
            // one shot, consumed by the next memory write
            inj_idx_a <= '0;
            inj_en_a  <= 1'b0;
            inj_idx_b <= '0;
            inj_en_b  <= 1'b0;
         end
      end
   end

   assign inject_mask = (codeword_t'(inj_en_a) << inj_idx_a) |
                        (codeword_t'(inj_en_b) << inj_idx_b);

   always_ff @(posedge clk)
   begin
      if (!rst_l)
      begin
         single_count <= '0;
         double_count <= '0;
      end
      else if (reg_wr && reg_sel == REG_STATUS_ADR)
      begin
         single_count <= '0;   // any write clears both
         double_count <= '0;
      end
      else
      begin
         if (count_single && single_count != '1)
            single_count <= single_count + 1'b1;
         if (count_double && double_count != '1)
            double_count <= double_count + 1'b1;
      end
   end

   always_comb
   begin
      case (reg_sel)
         REG_CTRL_ADR:
            reg_rdata = data_t'(detect_only);
         REG_INJECT_ADR:
            reg_rdata = data_t'({inj_en_b, inj_idx_b, 1'b0, inj_en_a, inj_idx_a});
         REG_STATUS_ADR:
            reg_rdata = data_t'({double_count, single_count});
         default:
            reg_rdata = '0;   // memory space and unmapped
      endcase
   end

endmodule

`default_nettype wire

// ==== design/ecc_word_store.sv ====
// ECC codeword array
`timescale 1ns/100ps
`default_nettype none

module ecc_word_store
   import ecc_mem_pkg::*;
(
   input  logic       clk,
   input  logic       wr_en,
   input  word_addr_t wr_addr,
   input  codeword_t  wr_code,
   input  logic       rd_en,
   input  word_addr_t rd_addr,
   output codeword_t  rd_code
);

   codeword_t mem [MEM_DEPTH];

   // behaves like a single-cycle RAM macro
   always_ff @(posedge clk)
   begin
      if (wr_en)
         mem[wr_addr] <= wr_code;
      if (rd_en)
         rd_code <= mem[rd_addr];   // valid the cycle after rd_en
   end

endmodule

`default_nettype wire

// ==== design/secded_decode.sv ====
// SECDED decoder
`timescale 1ns/100ps
`default_nettype none

module secded_decode
   import ecc_mem_pkg::*;
(
   input  codeword_t code,
   input  logic      detect_only,
   output data_t     data,
   output logic      single_err,
   output logic      double_err
);

   syndrome_t syn;
   logic      par;      // odd overall parity
   logic      s_nz;
   logic      s_hit;    // syndrome points at a real position
   logic      fix;
   codeword_t fixed;

   assign syn   = code_syndrome(code);
   assign par   = ^code;
   assign s_nz  = (syn != '0);
   assign s_hit = s_nz && (syn < syndrome_t'(CODE_W));

   always_comb
   begin
      if (detect_only)
      begin
         // no correction, every error counts as uncorrectable
         single_err = 1'b0;
         double_err = par | s_nz;
      end
      else
      begin
         single_err = par & (~s_nz | s_hit);
         double_err = (par & s_nz & ~s_hit) | (~par & s_nz);
      end
   end

   // a parity-only error leaves the data bits alone
   assign fix   = ~detect_only & par & s_hit;
   assign fixed = fix ? (code ^ (codeword_t'(1) << syn)) : code;

   always_comb
   begin
      int unsigned d;
      data = '0;
      d    = 0;
      for (int pos = 1; pos < CODE_W; pos++)
      begin
         if (is_data_pos(pos))
         begin
            data[d] = fixed[pos];
            d++;
         end
      end
   end

endmodule

`default_nettype wire

// ==== design/secded_encode.sv ====
// SECDED encoder
`timescale 1ns/100ps
`default_nettype none

module secded_encode
   import ecc_mem_pkg::*;
(
   input  data_t     data,
   output codeword_t code
);

   codeword_t placed;   // data bits in place, check and parity bits zero
   syndrome_t syn;

   always_comb
   begin
      int unsigned d;
      placed = '0;
      d      = 0;
      for (int pos = 1; pos < CODE_W; pos++)
      begin
         if (is_data_pos(pos))
         begin
            placed[pos] = data[d];
            d++;
         end
      end
   end

   assign syn = code_syndrome(placed);

   // each check bit cancels its share of the data syndrome
   always_comb
   begin
      code = placed;
      for (int k = 0; k < CHECK_W; k++)
         code[1 << k] = syn[k];
      code[0] = ^code[CODE_W-1:1];   // even parity over the whole word
   end

endmodule

`default_nettype wire

// ==== design/ecc_mem_pkg.sv ====
// ECC memory shared definitions
`default_nettype none

package ecc_mem_pkg;

   localparam int DATA_W    = 32;
   localparam int CHECK_W   = 6;
   localparam int CODE_W    = DATA_W + CHECK_W + 1;   // data, hamming and overall parity
   localparam int MEM_DEPTH = 16;

   typedef logic [DATA_W-1:0]  data_t;
   typedef logic [CODE_W-1:0]  codeword_t;
   typedef logic [CHECK_W-1:0] syndrome_t;
   typedef logic [5:0]         bit_idx_t;
   typedef logic [3:0]         word_addr_t;
   typedef logic [4:0]         wb_adr_t;
   typedef logic [7:0]         err_count_t;

   // register space sits above the word array
   localparam wb_adr_t REG_CTRL_ADR   = 5'd16;
   localparam wb_adr_t REG_INJECT_ADR = 5'd17;
   localparam wb_adr_t REG_STATUS_ADR = 5'd18;

   typedef enum logic [1:0] {
      bus_idle,
      bus_read,
      bus_done
   } bus_state_t;

   // positions that are neither parity nor a power of two carry data
   function automatic logic is_data_pos(int pos);
      return (pos > 0) && ((pos & (pos - 1)) != 0);
   endfunction

   // xor of the indices of all set bits above the parity bit
   function automatic syndrome_t code_syndrome(codeword_t c);
      syndrome_t s;
      s = '0;
      for (int pos = 1; pos < CODE_W; pos++)
      begin
         if (c[pos])
            s ^= syndrome_t'(pos);
      end
      return s;
   endfunction

endpackage

`default_nettype wire
